//--- testbench/edpPatterns.txt
// One step per line: ctrl dataA dataB expEbus (hex); a ctrl of all ones ends the list
// ctrl nibbles 17..0: flags(chk,chkPar,drv,par) adFunc adaSel adbSel {adaEn,cin} arlSel arrSel
//   {arLLd,arRLd,arLClr,arRClr} arxSel {arxLd,brLd,brxLd} mqSel mqmSel {mqmEn} fmAddr(2)
//   {fmWL,fmWR} {diagRead,adToL,adToR} diagFunc; dataA feeds cache and shift, dataB ebusIn and pc
// Reset state
800000000030000000 000000000 000000000 000000000
a00000000030000080 000000000 000000000 000000000
a00000000030000081 000000000 000000000 000000000
a00000000030000082 000000000 000000000 000000000
a00000000030000085 000000000 000000000 000000000
// AR halfwords, clear beats load, copy to BR
0000013c0030000000 123456789 abcdef012 000000000
a00000000030000080 000000000 000000000 12346f012
000000350030000000 000000000 abcdef012 000000000
a00000000030000080 000000000 000000000 123440000
000000000430000000 000000000 000000000 000000000
a00000000030000081 000000000 000000000 123440000
// Adder on AR and BR
0000011c0030000000 fedcba987 000000000 000000000
a00200000030000060 000000000 000000000 1110fa987
a10200000030000060 000000000 000000000 eca87a987
a20200000030000060 000000000 000000000 121400000
a40200000030000060 000000000 000000000 ece8fa987
a60200000030000060 000000000 000000000 123440000
a00200000030000040 000000000 000000000 1110c0000
// MQ load, shift left with carry 1, shift right
050200000002800000 000000000 000000000 000000000
000200000010000000 000000000 000000000 000000000
a00000000030000082 000000000 000000000 fdb97530f
000000000020000000 000000000 000000000 000000000
a00000000030000082 000000000 000000000 fedcba987
// FM halfword writes to addresses 5 and 9
000000000030005800 000000000 000000000 000000000
000000000030009400 000000000 000000000 000000000
0000011c0030000000 555555555 000000000 000000000
000000000030005400 000000000 000000000 000000000
000000000030009800 000000000 000000000 000000000
000000000030005000 000000000 000000000 000000000
e00000000030005083 000000000 000000000 fedc95555
000000000030009000 000000000 000000000 000000000
f00000000030009083 000000000 000000000 55557a987
// ARX from MQ, BRX copy, BR shifted with BRX bit 0
000000006830000000 000000000 000000000 000000000
000000000230000000 000000000 000000000 000000000
a00000000030000085 000000000 000000000 fedcba987
a00000000030000084 000000000 000000000 fedcba987
a00100000030000060 000000000 000000000 79bdd5556
ffffffffffffffffff 000000000 000000000 000000000

//--- list.f
source/edpPkg.sv
source/adderSlice.sv
source/adUnit.sv
source/arRegs.sv
source/mqShifter.sv
source/fastMem.sv
source/ebusDriver.sv
source/edp.sv
testbench/edp_props.sv
testbench/edpChecker.sv
testbench/edpTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module edpTb -f list.f -o simEdp
./obj_dir/simEdp 2>&1 | tee sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

//--- testbench/edpTb.sv
`timescale 1ns/100ps

module edpTb;

  localparam int maxSteps = 64;
  localparam int fieldsPerStep = 4;
  localparam int clkPeriod = 20;
  localparam logic [71:0] idleCtrl = 72'h000000000030000000;
  localparam logic [71:0] endMarker = '1;

  logic [71:0] patMem [maxSteps * fieldsPerStep];
  logic        eboxClk = 1'b0;
  logic        rst;
  logic        stepsKnown = 1'b0;
  int          numSteps;
  int          errorCount;
  int          checkCount;

  logic [0:2]                          adFunc, arlSel, arrSel, arxSel, diagFunc;
  logic [0:1]                          adaSel, adbSel, mqSel, mqmSel;
  logic                                adaEn, adCarryIn, mqmEn;
  logic                                arLeftLoad, arRightLoad, arLeftClr, arRightClr;
  logic                                arxLoad, brLoad, brxLoad;
  logic [0:edpPkg::fmAddrBits-1]       fmAddr;
  logic                                fmWriteLeft, fmWriteRight;
  logic                                diagRead, adToEbusLeft, adToEbusRight;
  logic [0:edpPkg::wordBits-1]         cacheDataRead, ebusIn, shiftIn, pcIn;
  logic [0:edpPkg::halfBits-1]         armmIn;
  logic [0:edpPkg::wordBits-1]         ebusData;
  logic                                ebusDriving, fmParity, adCarryOut, adOverflow;

  // Expected values of the current step
  logic                                chkEbus, chkParity, expDriving, expParity;
  logic [0:edpPkg::wordBits-1]         expEbus;

  always #(clkPeriod / 2) eboxClk = ~eboxClk;

  edp #(
    .fmDepth (edpPkg::fmWords)
  ) i_edp (.*);

  edpChecker resultChecker (.*);

  // Unpacks one pattern line onto the DUT inputs
  task automatic applyStep(input logic [71:0] ctrl, input logic [71:0] dataA,
                           input logic [71:0] dataB, input logic [71:0] expWord);
    chkEbus = ctrl[71];
    chkParity = ctrl[70];
    expDriving = ctrl[69];
    expParity = ctrl[68];
    adFunc = ctrl[66:64];
    adaSel = ctrl[61:60];
    adbSel = ctrl[57:56];
    adaEn = ctrl[55];
    adCarryIn = ctrl[54];
    arlSel = ctrl[50:48];
    arrSel = ctrl[46:44];
    arLeftLoad = ctrl[43];
    arRightLoad = ctrl[42];
    arLeftClr = ctrl[41];
    arRightClr = ctrl[40];
    arxSel = ctrl[38:36];
    arxLoad = ctrl[35];
    brLoad = ctrl[34];
    brxLoad = ctrl[33];
    mqSel = ctrl[29:28];
    mqmSel = ctrl[25:24];
    mqmEn = ctrl[23];
    fmAddr = ctrl[18:12];
    fmWriteLeft = ctrl[11];
    fmWriteRight = ctrl[10];
    diagRead = ctrl[7];
    adToEbusLeft = ctrl[6];
    adToEbusRight = ctrl[5];
    diagFunc = ctrl[2:0];
    cacheDataRead = dataA[35:0];
    shiftIn = dataA[35:0];
    ebusIn = dataB[35:0];
    pcIn = dataB[35:0];
    armmIn = dataB[17:0];
    expEbus = expWord[35:0];
  endtask

  initial begin
    $readmemh("testbench/edpPatterns.txt", patMem);
    numSteps = 0;
    while (numSteps < maxSteps && patMem[numSteps * fieldsPerStep] != endMarker) begin
      numSteps++;
    end
    stepsKnown = 1'b1;
    rst = 1'b1;
    applyStep(idleCtrl, '0, '0, '0);
    repeat (10) @(posedge eboxClk);
    #2;
    rst = 1'b0;
    for (int s = 0; s < numSteps; s++) begin
      @(posedge eboxClk);
      #2;
      applyStep(patMem[s * fieldsPerStep], patMem[s * fieldsPerStep + 1],
                patMem[s * fieldsPerStep + 2], patMem[s * fieldsPerStep + 3]);
    end
    @(posedge eboxClk);
    #2;
    applyStep(idleCtrl, '0, '0, '0);
    // Lets the last result reach the checker
    repeat (2) @(posedge eboxClk);
    $display("Steps: %0d, checks: %0d, errors: %0d", numSteps, checkCount, errorCount);
    if (errorCount == 0 && checkCount > 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (stepsKnown);
    #((numSteps + 20) * clkPeriod);
    $display("Timeout: the pattern run did not end within %0d cycles", numSteps + 20);
    $display("TB FAILED");
    $finish;
  end

endmodule

//--- testbench/edpChecker.sv
`timescale 1ns/100ps

module edpChecker (
  input  logic                        eboxClk,
  input  logic                        rst,
  input  logic                        chkEbus,
  input  logic                        chkParity,
  input  logic                        expDriving,
  input  logic                        expParity,
  input  logic [0:edpPkg::wordBits-1] expEbus,
  input  logic [0:edpPkg::wordBits-1] ebusData,
  input  logic                        ebusDriving,
  input  logic                        fmParity,
  output int                          errorCount,
  output int                          checkCount
);

  logic                        pendEbus;
  logic                        pendParity;
  logic                        pendDriving;
  logic                        pendParityVal;
  logic [0:edpPkg::wordBits-1] pendData;

  // Strobes of a step show up after the edge that takes them
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      pendEbus <= 1'b0;
      pendParity <= 1'b0;
      pendDriving <= 1'b0;
      pendParityVal <= 1'b0;
      pendData <= '0;
    end else begin
      pendEbus <= chkEbus;
      pendParity <= chkParity;
      pendDriving <= expDriving;
      pendParityVal <= expParity;
      pendData <= expEbus;
    end
  end

  // Outputs are settled by mid cycle
  always @(negedge eboxClk) begin
    if (rst) begin
      errorCount = 0;
      checkCount = 0;
    end else begin
      if (pendEbus) begin
        checkCount++;
        if (ebusData !== pendData) begin
          errorCount++;
          $display("[FAIL] t=%0t ebusData expected=%h got=%h", $time, pendData, ebusData);
        end
        if (ebusDriving !== pendDriving) begin
          errorCount++;
          $display("[FAIL] t=%0t ebusDriving expected=%b got=%b", $time, pendDriving,
                   ebusDriving);
        end
      end
      if (pendParity) begin
        checkCount++;
        if (fmParity !== pendParityVal) begin
          errorCount++;
          $display("[FAIL] t=%0t fmParity expected=%b got=%b", $time, pendParityVal, fmParity);
        end
      end
    end
  end

endmodule

//--- testbench/edp_props.sv
`timescale 1ns/100ps

module edp_props (
  input logic                        eboxClk,
  input logic                        rst,
  input logic                        diagRead,
  input logic                        adToEbusLeft,
  input logic                        adToEbusRight,
  input logic [0:edpPkg::wordBits-1] ebusData,
  input logic                        ebusDriving
);

  logic strobeSeen;

  assign strobeSeen = diagRead | adToEbusLeft | adToEbusRight;

  resetIdle: assert property (@(posedge eboxClk) rst |=> !ebusDriving)
    else $error("ebusDriving high in the cycle after reset");

  quietBus: assert property (@(posedge eboxClk) disable iff (rst)
    !ebusDriving |-> ebusData == '0)
    else $error("ebusData nonzero while the EBUS is not driven");

  // One cycle behind the strobes, none taken during reset
  drivingFollows: assert property (@(posedge eboxClk) disable iff (rst)
    ebusDriving == $past(strobeSeen && !rst))
    else $error("ebusDriving does not follow the strobes by one cycle");

endmodule

bind ebusDriver edp_props ebusProps (.*);

//--- source/edp.sv
`timescale 1ns/100ps

module edp #(
  parameter int fmDepth = edpPkg::fmWords
) (
  input  logic                          eboxClk,
  input  logic                          rst,
  input  logic [0:2]                    adFunc,
  input  logic [0:1]                    adaSel,
  input  logic                          adaEn,
  input  logic [0:1]                    adbSel,
  input  logic                          adCarryIn,
  input  logic [0:2]                    arlSel,
  input  logic [0:2]                    arrSel,
  input  logic                          arLeftLoad,
  input  logic                          arRightLoad,
  input  logic                          arLeftClr,
  input  logic                          arRightClr,
  input  logic [0:2]                    arxSel,
  input  logic                          arxLoad,
  input  logic [0:1]                    mqSel,
  input  logic [0:1]                    mqmSel,
  input  logic                          mqmEn,
  input  logic                          brLoad,
  input  logic                          brxLoad,
  input  logic [0:edpPkg::fmAddrBits-1] fmAddr,
  input  logic                          fmWriteLeft,
  input  logic                          fmWriteRight,
  input  logic                          diagRead,
  input  logic [0:2]                    diagFunc,
  input  logic                          adToEbusLeft,
  input  logic                          adToEbusRight,
  input  logic [0:edpPkg::wordBits-1]   cacheDataRead,
  input  logic [0:edpPkg::wordBits-1]   ebusIn,
  input  logic [0:edpPkg::wordBits-1]   shiftIn,
  input  logic [0:edpPkg::halfBits-1]   armmIn,
  input  logic [0:edpPkg::wordBits-1]   pcIn,
  output logic [0:edpPkg::wordBits-1]   ebusData,
  output logic                          ebusDriving,
  output logic                          fmParity,
  output logic                          adCarryOut,
  output logic                          adOverflow
);

  logic [0:edpPkg::wordBits-1] ar, arx, br, brx;
  logic [0:edpPkg::wordBits-1] mq;
  logic [0:edpPkg::wordBits-1] ad;
  logic [0:edpPkg::wordBits-1] fmData;

  arRegs iArRegs (
    .eboxClk, .rst, .arlSel, .arrSel, .arLeftLoad, .arRightLoad,
    .arLeftClr, .arRightClr, .arxSel, .arxLoad, .brLoad, .brxLoad,
    .ad, .mq, .cacheDataRead, .ebusIn, .shiftIn, .armmIn,
    .ar, .arx, .br, .brx
  );

  mqShifter iMqShifter (
    .eboxClk, .rst, .mqSel, .mqmSel, .mqmEn, .ad, .shiftIn, .adCarryOut, .mq
  );

  // Combinational from this cycle's register outputs
  adUnit iAdUnit (
    .ar, .arx, .mq, .br, .brx, .fmData, .pcIn, .adaSel, .adaEn, .adbSel,
    .adFunc, .adCarryIn, .ad, .adCarryOut, .adOverflow
  );

  fastMem #(
    .fmDepth (fmDepth)
  ) iFastMem (
    .eboxClk, .fmAddr, .fmWriteLeft, .fmWriteRight, .ar, .fmData, .fmParity
  );

  ebusDriver iEbusDriver (
    .eboxClk, .rst, .diagRead, .diagFunc, .adToEbusLeft, .adToEbusRight,
    .ar, .br, .mq, .fmData, .brx, .arx, .ad, .ebusData, .ebusDriving
  );

endmodule

//--- source/ebusDriver.sv
`timescale 1ns/100ps

module ebusDriver (
  input  logic                        eboxClk,
  input  logic                        rst,
  input  logic                        diagRead,
  input  logic [0:2]                  diagFunc,
  input  logic                        adToEbusLeft,
  input  logic                        adToEbusRight,
  input  logic [0:edpPkg::wordBits-1] ar,
  input  logic [0:edpPkg::wordBits-1] br,
  input  logic [0:edpPkg::wordBits-1] mq,
  input  logic [0:edpPkg::wordBits-1] fmData,
  input  logic [0:edpPkg::wordBits-1] brx,
  input  logic [0:edpPkg::wordBits-1] arx,
  input  logic [0:edpPkg::wordBits-1] ad,
  output logic [0:edpPkg::wordBits-1] ebusData,
  output logic                        ebusDriving
);

  edpPkg::tHalfWord srcWord;
  edpPkg::tHalfWord maskedWord;
  logic             anyStrobe;
  logic [0:2]       srcSel;

  assign anyStrobe = diagRead | adToEbusLeft | adToEbusRight;

  // Either AD strobe overrides the diagnostic function
  assign srcSel = (adToEbusLeft | adToEbusRight) ? edpPkg::diagAd : diagFunc;

  always_comb begin
    unique case (srcSel)
      edpPkg::diagAr:   srcWord.full = ar;
      edpPkg::diagBr:   srcWord.full = br;
      edpPkg::diagMq:   srcWord.full = mq;
      edpPkg::diagFm:   srcWord.full = fmData;
      edpPkg::diagBrx:  srcWord.full = brx;
      edpPkg::diagArx:  srcWord.full = arx;
      edpPkg::diagZero: srcWord.full = '0;
      default:          srcWord.full = ad;
    endcase
  end

  // A half goes out only for a diag read or its own AD strobe
  always_comb begin
    maskedWord.half.left = (diagRead | adToEbusLeft) ? srcWord.half.left : '0;
    maskedWord.half.right = (diagRead | adToEbusRight) ? srcWord.half.right : '0;
  end

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      ebusData <= '0;
      ebusDriving <= 1'b0;
    end else begin
      ebusDriving <= anyStrobe;
      ebusData <= anyStrobe ? maskedWord.full : '0;
    end
  end

endmodule

//--- source/fastMem.sv
`timescale 1ns/100ps

module fastMem #(
  parameter int fmDepth = 128
) (
  input  logic                          eboxClk,
  input  logic [0:edpPkg::fmAddrBits-1] fmAddr,
  input  logic                          fmWriteLeft,
  input  logic                          fmWriteRight,
  input  logic [0:edpPkg::wordBits-1]   ar,
  output logic [0:edpPkg::wordBits-1]   fmData,
  output logic                          fmParity
);

  logic [0:edpPkg::wordBits-1] mem [fmDepth];

  // Each half has its own write enable, data always comes from AR
  always_ff @(posedge eboxClk) begin
    if (fmWriteLeft) begin
      mem[fmAddr][0:17] <= ar[0:17];
    end
    if (fmWriteRight) begin
      mem[fmAddr][18:35] <= ar[18:35];
    end
  end

  // Read returns the word as it was before a same-edge write
  always_ff @(posedge eboxClk) begin
    fmData <= mem[fmAddr];
  end

  assign fmParity = ^fmData;

endmodule

//--- source/mqShifter.sv
`timescale 1ns/100ps

module mqShifter (
  input  logic                        eboxClk,
  input  logic                        rst,
  input  logic [0:1]                  mqSel,
  input  logic [0:1]                  mqmSel,
  input  logic                        mqmEn,
  input  logic [0:edpPkg::wordBits-1] ad,
  input  logic [0:edpPkg::wordBits-1] shiftIn,
  input  logic                        adCarryOut,
  output logic [0:edpPkg::wordBits-1] mq
);

  logic [0:edpPkg::wordBits-1] mqm;

  // MQM mux, zero when not enabled
  always_comb begin
    if (!mqmEn) begin
      mqm = '0;
    end else begin
      unique case (mqmSel)
        2'd0:    mqm = {mq[34:35], mq[0:33]};
        2'd1:    mqm = shiftIn;
        2'd2:    mqm = ad;
        default: mqm = '1;
      endcase
    end
  end

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      mq <= '0;
    end else begin
      unique case (mqSel)
        edpPkg::usrLoad: mq <= mqm;
        // No ADX here, so the AD carry feeds the low end
        edpPkg::usrShl:  mq <= {mq[1:35], adCarryOut};
        edpPkg::usrShr:  mq <= {mq[0], mq[0:34]};
        default:         mq <= mq;
      endcase
    end
  end

endmodule

//--- source/arRegs.sv
`timescale 1ns/100ps

module arRegs (
  input  logic                        eboxClk,
  input  logic                        rst,
  input  logic [0:2]                  arlSel,
  input  logic [0:2]                  arrSel,
  input  logic                        arLeftLoad,
  input  logic                        arRightLoad,
  input  logic                        arLeftClr,
  input  logic                        arRightClr,
  input  logic [0:2]                  arxSel,
  input  logic                        arxLoad,
  input  logic                        brLoad,
  input  logic                        brxLoad,
  input  logic [0:edpPkg::wordBits-1] ad,
  input  logic [0:edpPkg::wordBits-1] mq,
  input  logic [0:edpPkg::wordBits-1] cacheDataRead,
  input  logic [0:edpPkg::wordBits-1] ebusIn,
  input  logic [0:edpPkg::wordBits-1] shiftIn,
  input  logic [0:edpPkg::halfBits-1] armmIn,
  output logic [0:edpPkg::wordBits-1] ar,
  output logic [0:edpPkg::wordBits-1] arx,
  output logic [0:edpPkg::wordBits-1] br,
  output logic [0:edpPkg::wordBits-1] brx
);

  edpPkg::tHalfWord              arCand [8];
  edpPkg::tHalfWord              arReg;
  logic [0:edpPkg::halfBits-1]   arLeft;
  logic [0:edpPkg::halfBits-1]   arRight;
  logic [0:edpPkg::wordBits-1]   arxMux;

  // Eight full-word candidates, each half picks its own
  always_comb begin
    arCand[edpPkg::srcArmm].full = {armmIn, armmIn};
    arCand[edpPkg::srcCache].full = cacheDataRead;
    arCand[edpPkg::srcAd].full = ad;
    arCand[edpPkg::srcEbus].full = ebusIn;
    arCand[edpPkg::srcShift].full = shiftIn;
    arCand[edpPkg::srcAdShl].full = {ad[1:35], 1'b0};
    arCand[edpPkg::srcMq].full = mq;
    // AD over two, sign copied in
    arCand[edpPkg::srcAdShr].full = {ad[0], ad[0], ad[0:33]};
  end

  assign arLeft = arCand[arlSel].half.left;
  assign arRight = arCand[arrSel].half.right;

  // ARX sees MQ where AR sees EBUS, and zero in place of ARMM
  always_comb begin
    case (arxSel)
      edpPkg::srcArmm:              arxMux = '0;
      edpPkg::srcEbus, edpPkg::srcMq: arxMux = mq;
      default:                      arxMux = arCand[arxSel].full;
    endcase
  end

  // Clear of a half beats its load
  always_ff @(posedge eboxClk) begin
    if (rst) begin
      arReg <= '0;
    end else begin
      if (arLeftClr) begin
        arReg.half.left <= '0;
      end else if (arLeftLoad) begin
        arReg.half.left <= arLeft;
      end
      if (arRightClr) begin
        arReg.half.right <= '0;
      end else if (arRightLoad) begin
        arReg.half.right <= arRight;
      end
    end
  end

  assign ar = arReg.full;

  always_ff @(posedge eboxClk) begin
    if (rst) begin
      arx <= '0;
      br <= '0;
      brx <= '0;
    end else begin
      if (arxLoad) begin
        arx <= arxMux;
      end
      if (brLoad) begin
        br <= ar;
      end
      if (brxLoad) begin
        brx <= arx;
      end
    end
  end

endmodule

//--- source/adUnit.sv
`timescale 1ns/100ps

module adUnit (
  input  logic [0:edpPkg::wordBits-1] ar,
  input  logic [0:edpPkg::wordBits-1] arx,
  input  logic [0:edpPkg::wordBits-1] mq,
  input  logic [0:edpPkg::wordBits-1] br,
  input  logic [0:edpPkg::wordBits-1] brx,
  input  logic [0:edpPkg::wordBits-1] fmData,
  input  logic [0:edpPkg::wordBits-1] pcIn,
  input  logic [0:1]                  adaSel,
  input  logic                        adaEn,
  input  logic [0:1]                  adbSel,
  input  logic [0:2]                  adFunc,
  input  logic                        adCarryIn,
  output logic [0:edpPkg::wordBits-1] ad,
  output logic                        adCarryOut,
  output logic                        adOverflow
);

  localparam int numSlices = edpPkg::wordBits / edpPkg::sliceBits;

  logic [0:edpPkg::wordBits-1] ada;
  logic [0:edpPkg::wordBits-1] adb;
  logic [0:numSlices-1]        sliceGen;
  logic [0:numSlices-1]        sliceProp;
  logic [0:numSlices-1]        sliceCarry;
  logic                        carryIn;
  logic                        isSub;
  logic                        grpGenLo, grpPropLo;
  logic                        grpGenHi, grpPropHi;
  logic                        carryIntoBit0;

  always_comb begin
    unique case (adaSel)
      edpPkg::adaAr:  ada = ar;
      edpPkg::adaArx: ada = arx;
      edpPkg::adaMq:  ada = mq;
      default:        ada = pcIn;
    endcase
    if (adaEn) ada = '0;
  end

  // Shifted forms pull low bits in from the extension register
  always_comb begin
    unique case (adbSel)
      edpPkg::adbFm:   adb = fmData;
      edpPkg::adbBrx2: adb = {br[1:35], brx[0]};
      edpPkg::adbBr:   adb = br;
      default:         adb = {ar[2:35], arx[0:1]};
    endcase
  end

  assign isSub = (adFunc == edpPkg::adSub);
  assign carryIn = isSub ? 1'b1 : adCarryIn;

  for (genvar i = 0; i < numSlices; i++) begin : genSlice
    adderSlice iSlice (
      .a       (ada[i*edpPkg::sliceBits +: edpPkg::sliceBits]),
      .b       (adb[i*edpPkg::sliceBits +: edpPkg::sliceBits]),
      .carryIn (sliceCarry[i]),
      .func    (adFunc),
      .f       (ad[i*edpPkg::sliceBits +: edpPkg::sliceBits]),
      .gen     (sliceGen[i]),
      .prop    (sliceProp[i])
    );
  end

  // First level, low group of slices 3 to 5
  assign sliceCarry[5] = carryIn;
  assign sliceCarry[4] = sliceGen[5] | (sliceProp[5] & carryIn);
  assign sliceCarry[3] = sliceGen[4] | (sliceProp[4] & sliceGen[5])
                       | (sliceProp[4] & sliceProp[5] & carryIn);
  assign grpGenLo = sliceGen[3] | (sliceProp[3] & sliceGen[4])
                  | (sliceProp[3] & sliceProp[4] & sliceGen[5]);
  assign grpPropLo = &sliceProp[3:5];

  // Second level carries into the high group
  assign sliceCarry[2] = grpGenLo | (grpPropLo & carryIn);
  assign sliceCarry[1] = sliceGen[2] | (sliceProp[2] & sliceCarry[2]);
  assign sliceCarry[0] = sliceGen[1] | (sliceProp[1] & sliceGen[2])
                       | (sliceProp[1] & sliceProp[2] & sliceCarry[2]);
  assign grpGenHi = sliceGen[0] | (sliceProp[0] & sliceGen[1])
                  | (sliceProp[0] & sliceProp[1] & sliceGen[2]);
  assign grpPropHi = &sliceProp[0:2];

  assign adCarryOut = grpGenHi | (grpPropHi & sliceCarry[2]);

  // Recover the carry into the sign bit from its sum
  assign carryIntoBit0 = ada[0] ^ adb[0] ^ isSub ^ ad[0];
  assign adOverflow = ((adFunc == edpPkg::adAdd) || isSub) & (carryIntoBit0 ^ adCarryOut);

endmodule

//--- source/adderSlice.sv
`timescale 1ns/100ps

module adderSlice (
  input  logic [0:edpPkg::sliceBits-1] a,
  input  logic [0:edpPkg::sliceBits-1] b,
  input  logic                         carryIn,
  input  logic [0:2]                   func,
  output logic [0:edpPkg::sliceBits-1] f,
  output logic                         gen,
  output logic                         prop
);

  logic [0:edpPkg::sliceBits-1] bEff;
  logic [0:edpPkg::sliceBits]   sumFull;
  logic [0:edpPkg::sliceBits]   sumNoCarry;
  logic                         isArith;

  // Subtraction is A plus inverted B with carry in forced by adUnit
  assign bEff = (func == edpPkg::adSub) ? ~b : b;
  assign isArith = (func == edpPkg::adAdd) || (func == edpPkg::adSub);

  assign sumFull = {1'b0, a} + {1'b0, bEff} + carryIn;
  assign sumNoCarry = {1'b0, a} + {1'b0, bEff};

  always_comb begin
    unique case (func)
      edpPkg::adAdd, edpPkg::adSub: f = sumFull[1:edpPkg::sliceBits];
      edpPkg::adAnd:   f = a & b;
      edpPkg::adOr:    f = a | b;
      edpPkg::adXor:   f = a ^ b;
      edpPkg::adPassA: f = a;
      edpPkg::adPassB: f = b;
      default:         f = '1;
    endcase
  end

  // Slice carries out when it generates, or propagates an incoming carry
  assign gen = isArith & sumNoCarry[0];
  assign prop = isArith & (&(a ^ bEff));

endmodule

//--- source/edpPkg.sv
package edpPkg;

  // Data path widths
  localparam int wordBits = 36;
  localparam int halfBits = 18;
  localparam int sliceBits = 6;

  // Fast memory geometry
  localparam int fmWords = 128;
  localparam int fmAddrBits = 7;

  // One word seen whole or as two halves
  typedef union packed {
    logic [0:wordBits-1] full;
    struct packed {
      logic [0:halfBits-1] left;
      logic [0:halfBits-1] right;
    } half;
  } tHalfWord;

  // Adder functions
  localparam logic [0:2] adAdd = 3'd0;
  localparam logic [0:2] adSub = 3'd1;
  localparam logic [0:2] adAnd = 3'd2;
  localparam logic [0:2] adOr = 3'd3;
  localparam logic [0:2] adXor = 3'd4;
  localparam logic [0:2] adPassA = 3'd5;
  localparam logic [0:2] adPassB = 3'd6;
  localparam logic [0:2] adOnes = 3'd7;

  // Adder A operand selects
  localparam logic [0:1] adaAr = 2'd0;
  localparam logic [0:1] adaArx = 2'd1;
  localparam logic [0:1] adaMq = 2'd2;
  localparam logic [0:1] adaPc = 2'd3;

  // Adder B operand selects
  localparam logic [0:1] adbFm = 2'd0;
  localparam logic [0:1] adbBrx2 = 2'd1;
  localparam logic [0:1] adbBr = 2'd2;
  localparam logic [0:1] adbArx4 = 2'd3;

  // AR and ARX sources
  localparam logic [0:2] srcArmm = 3'd0;
  localparam logic [0:2] srcCache = 3'd1;
  localparam logic [0:2] srcAd = 3'd2;
  localparam logic [0:2] srcEbus = 3'd3;
  localparam logic [0:2] srcShift = 3'd4;
  localparam logic [0:2] srcAdShl = 3'd5;
  localparam logic [0:2] srcMq = 3'd6;
  localparam logic [0:2] srcAdShr = 3'd7;

  // MQ universal shift register functions
  localparam logic [0:1] usrLoad = 2'd0;
  localparam logic [0:1] usrShl = 2'd1;
  localparam logic [0:1] usrShr = 2'd2;
  localparam logic [0:1] usrHold = 2'd3;

  // Diagnostic read sources
  localparam logic [0:2] diagAr = 3'd0;
  localparam logic [0:2] diagBr = 3'd1;
  localparam logic [0:2] diagMq = 3'd2;
  localparam logic [0:2] diagFm = 3'd3;
  localparam logic [0:2] diagBrx = 3'd4;
  localparam logic [0:2] diagArx = 3'd5;
  localparam logic [0:2] diagZero = 3'd6;
  localparam logic [0:2] diagAd = 3'd7;

endpackage
